/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Data, address or instruction word
    typedef logic [31:0] word_t;

    // RV32I major opcodes as found in inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate layout
    typedef enum logic [2:0] {
        IMM_I = 3'd0, // Loads, ALU immediates, jalr
        IMM_S = 3'd1, // Stores
        IMM_B = 3'd2, // Conditional branches
        IMM_U = 3'd3, // lui, auipc
        IMM_J = 3'd4  // jal
    } imm_sel_e;

    // Early target source
    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,
        TGT_JAL    = 2'd1,
        TGT_JALR   = 2'd2,
        TGT_BRANCH = 2'd3
    } tgt_sel_e;

    // Where the jalr base register comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0, // Register file
        FWD_EX   = 2'd1, // ALU result in EX
        FWD_MEM  = 2'd2, // ALU result in MEM
        FWD_WB   = 2'd3  // Write-back data
    } fwd_sel_e;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    // PC bit that maps fetch to the boot ROM
    localparam int unsigned BIOS_PC_BIT = 30;

endpackage

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  logic          clk,
    input  logic          we,
    input  logic [4:0]    ra1,
    input  logic [4:0]    ra2,
    input  logic [4:0]    wa,
    input  cpu_pkg::word_t wd,
    output cpu_pkg::word_t rd1,
    output cpu_pkg::word_t rd2
);
    cpu_pkg::word_t regs [1:31]; // x0 has no storage

    // Read logic, used for both read ports
    function automatic cpu_pkg::word_t read_port(input logic [4:0] ra);
        cpu_pkg::word_t val;
        if (ra == 5'd0) begin
            val = '0;
        end else if (we && (wa == ra)) begin
            val = wd; // Write-through of this cycle's WB
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

`default_nettype wire

/* imm_gen.sv */
`default_nettype none

module imm_gen (
    input  cpu_pkg::word_t   inst,
    input  cpu_pkg::imm_sel_e sel,
    output cpu_pkg::word_t   imm
);
    cpu_pkg::opcode_e op;
    logic             sign;

    assign op   = cpu_pkg::opcode_e'(inst[6:0]);
    assign sign = inst[31]; // All formats extend from bit 31

    always_comb begin
        unique case (sel)
            cpu_pkg::IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            cpu_pkg::IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            cpu_pkg::IMM_B: begin
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            cpu_pkg::IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            cpu_pkg::IMM_J: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase

        // R-type has no immediate field
        if (op == cpu_pkg::OP_REG) begin
            imm = '0;
        end
    end

endmodule

`default_nettype wire

/* target_gen.sv */
`default_nettype none

module target_gen (
    input  cpu_pkg::word_t   pc,
    input  cpu_pkg::tgt_sel_e sel,
    input  logic             en,
    input  cpu_pkg::word_t   rs1,
    input  cpu_pkg::word_t   imm,
    output cpu_pkg::word_t   target,
    output logic             target_taken,
    output logic             branch_taken
);
    cpu_pkg::word_t pc_rel;   // jal and branch target
    cpu_pkg::word_t reg_rel;  // jalr target before alignment

    assign pc_rel  = pc + imm;
    assign reg_rel = rs1 + imm;

    // Backward branch predicted taken
    assign branch_taken = (sel == cpu_pkg::TGT_BRANCH) && imm[31];

    always_comb begin
        unique case (sel)
            cpu_pkg::TGT_JALR: begin
                target = {reg_rel[31:1], 1'b0}; // LSB cleared per ISA
            end
            default: begin
                target = pc_rel;
            end
        endcase
    end

    always_comb begin
        unique case (sel)
            cpu_pkg::TGT_JAL,
            cpu_pkg::TGT_JALR: begin
                target_taken = en; // Unconditional jumps
            end
            cpu_pkg::TGT_BRANCH: begin
                target_taken = en && branch_taken;
            end
            default: begin
                target_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* id_control.sv */
`default_nettype none

module id_control (
    input  cpu_pkg::word_t    inst,
    input  cpu_pkg::word_t    ex_inst,
    input  cpu_pkg::word_t    mem_inst,
    input  cpu_pkg::word_t    wb_inst,
    output cpu_pkg::imm_sel_e imm_sel,
    output cpu_pkg::tgt_sel_e tgt_sel,
    output cpu_pkg::fwd_sel_e fwd_sel,
    output logic              tgt_en,
    output logic              stall
);
    cpu_pkg::opcode_e op;
    logic [4:0]       rs1;
    logic             is_jalr;

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;
    logic ex_load;
    logic mem_load;

    // True when i writes a nonzero rd that equals rs
    function automatic logic produces(input cpu_pkg::word_t i, input logic [4:0] rs);
        cpu_pkg::opcode_e i_op;
        logic             has_rd;
        i_op   = cpu_pkg::opcode_e'(i[6:0]);
        has_rd = (i_op != cpu_pkg::OP_STORE) && (i_op != cpu_pkg::OP_BRANCH);
        return has_rd && (i[11:7] != 5'd0) && (i[11:7] == rs);
    endfunction

    function automatic logic is_load(input cpu_pkg::word_t i);
        return i[6:0] == cpu_pkg::OP_LOAD;
    endfunction

    assign op      = cpu_pkg::opcode_e'(inst[6:0]);
    assign rs1     = inst[19:15];
    assign is_jalr = (op == cpu_pkg::OP_JALR);

    // Format and target selection
    always_comb begin
        imm_sel = cpu_pkg::IMM_I;
        tgt_sel = cpu_pkg::TGT_NONE;
        unique case (op)
            cpu_pkg::OP_LUI,
            cpu_pkg::OP_AUIPC: begin
                imm_sel = cpu_pkg::IMM_U;
            end
            cpu_pkg::OP_JAL: begin
                imm_sel = cpu_pkg::IMM_J;
                tgt_sel = cpu_pkg::TGT_JAL;
            end
            cpu_pkg::OP_JALR: begin
                tgt_sel = cpu_pkg::TGT_JALR;
            end
            cpu_pkg::OP_BRANCH: begin
                imm_sel = cpu_pkg::IMM_B;
                tgt_sel = cpu_pkg::TGT_BRANCH;
            end
            cpu_pkg::OP_STORE: begin
                imm_sel = cpu_pkg::IMM_S;
            end
            default: begin
                imm_sel = cpu_pkg::IMM_I; // Loads, OP-IMM, SYSTEM
            end
        endcase
    end

    // Producers of the jalr base, youngest first
    assign ex_hit   = produces(ex_inst, rs1);
    assign mem_hit  = produces(mem_inst, rs1);
    assign wb_hit   = produces(wb_inst, rs1);
    assign ex_load  = is_load(ex_inst);
    assign mem_load = is_load(mem_inst);

    always_comb begin
        fwd_sel = cpu_pkg::FWD_NONE;
        if (is_jalr) begin
            if (ex_hit) begin
                fwd_sel = cpu_pkg::FWD_EX;
            end else if (mem_hit) begin
                fwd_sel = cpu_pkg::FWD_MEM;
            end else if (wb_hit) begin
                fwd_sel = cpu_pkg::FWD_WB;
            end
        end
    end

    // Load data not ready until WB
    always_comb begin
        stall = 1'b0;
        if (is_jalr) begin
            if (ex_hit) begin
                stall = ex_load;
            end else if (mem_hit) begin
                stall = mem_load; // mem_alu still holds the address
            end
        end
    end

    assign tgt_en = ~stall;

endmodule

`default_nettype wire

/* id_stage.sv */
`default_nettype none

module id_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ex_flush,
    input  cpu_pkg::word_t id_pc,
    input  cpu_pkg::word_t id_bios_inst,
    input  cpu_pkg::word_t id_imem_inst,
    input  logic           wb_regwen,
    input  cpu_pkg::word_t ex_alu,   // Forwarding source for jalr
    input  cpu_pkg::word_t mem_alu,  // Forwarding source for jalr
    input  cpu_pkg::word_t mem_inst, // Hazard check only
    input  cpu_pkg::word_t wb_wdata, // Write data and forwarding source
    input  cpu_pkg::word_t wb_inst,  // Supplies write address
    output cpu_pkg::word_t id_target,
    output logic           id_target_taken,
    output logic           ex_br_taken,
    output cpu_pkg::word_t ex_pc,
    output cpu_pkg::word_t ex_rd1,
    output cpu_pkg::word_t ex_rd2,
    output cpu_pkg::word_t ex_imm,
    output cpu_pkg::word_t ex_inst,
    output logic           id_stall
);
    cpu_pkg::word_t    inst;
    cpu_pkg::word_t    rd1;
    cpu_pkg::word_t    rd2;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    jalr_base;
    cpu_pkg::imm_sel_e imm_sel;
    cpu_pkg::tgt_sel_e tgt_sel;
    cpu_pkg::fwd_sel_e fwd_sel;
    logic              tgt_en;
    logic              br_taken;
    logic              bubble;

    // Boot ROM when PC is in the BIOS region
    assign inst = id_pc[cpu_pkg::BIOS_PC_BIT] ? id_bios_inst : id_imem_inst;

    reg_file i_reg_file (
        .clk (clk),
        .we  (wb_regwen),
        .ra1 (inst[19:15]),
        .ra2 (inst[24:20]),
        .wa  (wb_inst[11:7]),
        .wd  (wb_wdata),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    imm_gen i_imm_gen (
        .inst (inst),
        .sel  (imm_sel),
        .imm  (imm)
    );

    id_control i_id_control (
        .inst     (inst),
        .ex_inst  (ex_inst),
        .mem_inst (mem_inst),
        .wb_inst  (wb_inst),
        .imm_sel  (imm_sel),
        .tgt_sel  (tgt_sel),
        .fwd_sel  (fwd_sel),
        .tgt_en   (tgt_en),
        .stall    (id_stall)
    );

    // jalr base forwarding
    always_comb begin
        unique case (fwd_sel)
            cpu_pkg::FWD_EX: begin
                jalr_base = ex_alu;
            end
            cpu_pkg::FWD_MEM: begin
                jalr_base = mem_alu;
            end
            cpu_pkg::FWD_WB: begin
                jalr_base = wb_wdata;
            end
            default: begin
                jalr_base = rd1;
            end
        endcase
    end

    target_gen i_target_gen (
        .pc           (id_pc),
        .sel          (tgt_sel),
        .en           (tgt_en),
        .rs1          (jalr_base),
        .imm          (imm),
        .target       (id_target),
        .target_taken (id_target_taken),
        .branch_taken (br_taken)
    );

    assign bubble = !rst_n || id_stall || ex_flush;

    // ID/EX registers
    always_ff @(posedge clk) begin
        if (bubble) begin
            ex_pc       <= '0;
            ex_rd1      <= '0;
            ex_rd2      <= '0;
            ex_imm      <= '0;
            ex_br_taken <= 1'b0;
            ex_inst     <= cpu_pkg::NOP; // Harmless in later stages
        end else begin
            ex_pc       <= id_pc;
            ex_rd1      <= rd1;
            ex_rd2      <= rd2;
            ex_imm      <= imm;
            ex_br_taken <= br_taken; // For misprediction check downstream
            ex_inst     <= inst;
        end
    end

endmodule

`default_nettype wire

/* id_stage_props.sv */
`default_nettype none

module id_stage_props (
    input logic           clk,
    input logic           rst_n,
    input logic           ex_flush,
    input logic           id_stall,
    input logic           id_target_taken,
    input logic           ex_br_taken,
    input cpu_pkg::word_t ex_inst
);
    int unsigned fail_count = 0; // Failed assertions so far

    // Stall or flush turns the next EX slot into a bubble
    a_bubble_on_hold: assert property (@(posedge clk)
        (id_stall || ex_flush) |=> (ex_inst == cpu_pkg::NOP))
        else begin
            fail_count++;
            $error("ex_inst is not a bubble after a stall or flush edge");
        end

    a_no_taken_on_stall: assert property (@(posedge clk)
        !(id_target_taken && id_stall))
        else begin
            fail_count++;
            $error("id_target_taken is high while id_stall is high");
        end

    // Reset loads the bubble
    a_reset_bubble: assert property (@(posedge clk)
        !rst_n |=> ((ex_inst == cpu_pkg::NOP) && !ex_br_taken))
        else begin
            fail_count++;
            $error("EX registers are not a bubble after a reset edge");
        end

endmodule

bind id_stage id_stage_props i_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_flush        (ex_flush),
    .id_stall        (id_stall),
    .id_target_taken (id_target_taken),
    .ex_br_taken     (ex_br_taken),
    .ex_inst         (ex_inst)
);

`default_nettype wire

/* tb_id_stage.sv */
`default_nettype none

module tb_id_stage;

    localparam int FIELDS        = 16; // Words per vector line
    localparam int MAX_VECTORS   = 64;
    localparam int HALF_PERIOD   = 20;
    localparam int DRIVE_DELAY   = 5;
    localparam int SAMPLE_DELAY  = 30; // Lands just before the next edge
    localparam int RESET_CYCLES  = 3;
    localparam int RESET_TIMEOUT = 8;
    localparam int MAX_CYCLES    = 300;
    localparam logic [31:0] END_MARK = 32'hff;

    logic           clk;
    logic           rst_n;
    logic           ex_flush;
    logic           wb_regwen;
    cpu_pkg::word_t id_pc;
    cpu_pkg::word_t id_bios_inst;
    cpu_pkg::word_t id_imem_inst;
    cpu_pkg::word_t ex_alu;
    cpu_pkg::word_t mem_alu;
    cpu_pkg::word_t mem_inst;
    cpu_pkg::word_t wb_wdata;
    cpu_pkg::word_t wb_inst;
    cpu_pkg::word_t id_target;
    logic           id_target_taken;
    logic           ex_br_taken;
    cpu_pkg::word_t ex_pc;
    cpu_pkg::word_t ex_rd1;
    cpu_pkg::word_t ex_rd2;
    cpu_pkg::word_t ex_imm;
    cpu_pkg::word_t ex_inst;
    logic           id_stall;

    logic [31:0] vec_mem [0:FIELDS*MAX_VECTORS-1];
    int          vec;
    logic        done;

    id_stage i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_flush        (ex_flush),
        .id_pc           (id_pc),
        .id_bios_inst    (id_bios_inst),
        .id_imem_inst    (id_imem_inst),
        .wb_regwen       (wb_regwen),
        .ex_alu          (ex_alu),
        .mem_alu         (mem_alu),
        .mem_inst        (mem_inst),
        .wb_wdata        (wb_wdata),
        .wb_inst         (wb_inst),
        .id_target       (id_target),
        .id_target_taken (id_target_taken),
        .ex_br_taken     (ex_br_taken),
        .ex_pc           (ex_pc),
        .ex_rd1          (ex_rd1),
        .ex_rd2          (ex_rd2),
        .ex_imm          (ex_imm),
        .ex_inst         (ex_inst),
        .id_stall        (id_stall)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        stop_run();
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h in vector %0d", name, exp, act, vec);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h in vector %0d", name, exp, act, vec);
            stop_run();
        end
    endtask

    task automatic check_props();
        if (i_dut.i_props.fail_count != 0) begin
            report_error("a bound property on the decode stage failed");
        end
    endtask

    task automatic wait_for_known_ex();
        int cycles;
        cycles = 0;
        while ($isunknown({ex_inst, ex_br_taken})) begin
            if (cycles >= RESET_TIMEOUT) begin
                report_error("EX registers stayed unknown after reset");
            end
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
    endtask

    task automatic apply_vector(input int b);
        logic [31:0] ctrl;
        ctrl         = vec_mem[b];
        ex_flush     = ctrl[1];
        wb_regwen    = ctrl[0];
        id_pc        = vec_mem[b + 1];
        id_bios_inst = vec_mem[b + 2];
        id_imem_inst = vec_mem[b + 3];
        ex_alu       = vec_mem[b + 4];
        mem_alu      = vec_mem[b + 5];
        mem_inst     = vec_mem[b + 6];
        wb_wdata     = vec_mem[b + 7];
        wb_inst      = vec_mem[b + 8];
    endtask

    task automatic check_comb(input int b);
        logic [31:0] flags;
        flags = vec_mem[b + 10];
        check_word("id_target", vec_mem[b + 9], id_target);
        check_flag("id_target_taken", flags[1], id_target_taken);
        check_flag("id_stall", flags[2], id_stall);
    endtask

    task automatic check_regs(input int b);
        logic [31:0] flags;
        flags = vec_mem[b + 10];
        check_flag("ex_br_taken", flags[0], ex_br_taken);
        check_word("ex_pc", vec_mem[b + 11], ex_pc);
        check_word("ex_rd1", vec_mem[b + 12], ex_rd1);
        check_word("ex_rd2", vec_mem[b + 13], ex_rd2);
        check_word("ex_imm", vec_mem[b + 14], ex_imm);
        check_word("ex_inst", vec_mem[b + 15], ex_inst);
    endtask

    // One vector per clock from edge plus DRIVE_DELAY to the next
    task automatic run_vector(input int b);
        apply_vector(b);
        #SAMPLE_DELAY;
        check_comb(b);
        @(posedge clk);
        #1;
        check_regs(b);
        check_props();
        #(DRIVE_DELAY - 1);
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        report_error("simulation ran past its cycle limit");
    end

    initial begin
        rst_n        = 1'b0;
        ex_flush     = 1'b0;
        wb_regwen    = 1'b0;
        id_pc        = '0;
        id_bios_inst = '0;
        id_imem_inst = '0;
        ex_alu       = '0;
        mem_alu      = '0;
        mem_inst     = '0;
        wb_wdata     = '0;
        wb_inst      = '0;
        vec          = 0;
        done         = 1'b0;
        $readmemh("id_stim.txt", vec_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        wait_for_known_ex();
        check_flag("ex_br_taken", 1'b0, ex_br_taken); // Bubble left by reset
        check_word("ex_pc", 32'h0, ex_pc);
        check_word("ex_rd1", 32'h0, ex_rd1);
        check_word("ex_rd2", 32'h0, ex_rd2);
        check_word("ex_imm", 32'h0, ex_imm);
        check_word("ex_inst", cpu_pkg::NOP, ex_inst);

        while (!done) begin
            if (vec >= MAX_VECTORS) begin
                report_error("no end marker found within the vector limit");
            end else if (vec_mem[vec * FIELDS] === END_MARK) begin
                done = 1'b1;
            end else if ($isunknown(vec_mem[vec * FIELDS])) begin
                report_error("vector file is missing or ended without an end marker");
            end else begin
                run_vector(vec * FIELDS);
                vec++;
            end
        end

        check_props();
        if (i_dut.i_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* id_stim.txt */
// Columns are ctrl pc bios imem ex_alu mem_alu mem_inst wb_wdata wb_inst, then the
// expected id_target flags ex_pc ex_rd1 ex_rd2 ex_imm ex_inst
// ctrl holds ex_flush in bit 1 and wb_regwen in bit 0
// flags holds id_stall in bit 2, id_target_taken in bit 1 and ex_br_taken in bit 0
// Register writes, instruction select, same-cycle bypass and x0
1 100 0 13 0 0 13 11111111 93 100 0 100 0 0 0 13
1 104 110233 2081b3 0 0 13 22222222 113 104 0 104 11111111 22222222 0 2081b3
0 40000008 110233 2081b3 0 0 13 0 13 40000008 0 40000008 22222222 11111111 0 110233
1 10 0 1002b3 0 0 13 ffffffff 13 10 0 10 0 11111111 0 1002b3
// I and S immediates
0 20 0 f0008313 0 0 13 0 13 ffffff20 0 20 11111111 0 ffffff00 f0008313
0 24 0 fe20aa23 0 0 13 0 13 18 0 24 11111111 22222222 fffffff4 fe20aa23
// Forward then backward branch
0 28 0 208863 0 0 13 0 13 38 0 28 11111111 22222222 10 208863
0 30 0 fe208ce3 0 0 13 0 13 28 3 30 11111111 22222222 fffffff8 fe208ce3
// U immediate and jal
0 34 0 fe0003b7 0 0 13 0 13 fe000034 0 34 0 0 fe000000 fe0003b7
0 38 0 7a0040ef 0 0 13 0 13 47d8 2 38 0 0 47a0 7a0040ef
// jalr base from the register file, WB, MEM and EX
0 3c 0 2110367 aaaa0000 bbbb0000 13 cccc0000 13 22222242 2 3c 22222222 11111111 21 2110367
0 40 0 2110367 aaaa0000 bbbb0000 13 30000000 113 30000020 2 40 22222222 11111111 21 2110367
0 44 0 2110367 aaaa0000 40000000 108133 30000000 113 40000020 2 44 22222222 11111111 21 2110367
0 48 0 100113 0 0 13 0 13 49 0 48 0 11111111 1 100113
0 4c 0 2110367 50000000 40000000 108133 30000000 113 50000020 2 4c 22222222 11111111 21 2110367
// Load to x2, then jalr on x2 stalls with the load in EX and in MEM
0 50 0 a103 0 0 13 0 13 50 0 50 11111111 0 0 a103
0 54 0 2110367 60000000 0 13 0 13 60000020 4 0 0 0 0 13
0 54 0 2110367 0 100 a103 0 13 120 4 0 0 0 0 13
1 54 0 2110367 0 0 13 70000000 a103 70000020 2 54 70000000 11111111 21 2110367
// Flush over a plain op and over a taken branch
2 58 0 2081b3 0 0 13 0 13 58 0 0 0 0 0 13
2 5c 0 fe208ce3 0 0 13 0 13 54 2 0 0 0 0 13
0 60 0 13 0 0 13 0 13 60 0 60 0 0 0 13
// End marker
ff

/* src.f */
cpu_pkg.sv
reg_file.sv
imm_gen.sv
target_gen.sv
id_control.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - cpu_pkg.sv
  - reg_file.sv
  - imm_gen.sv
  - target_gen.sv
  - id_control.sv
  - id_stage.sv
  - target: test
    files:
      - id_stage_props.sv
      - tb_id_stage.sv
